//--- logic/hmr_pkg.sv
package hmr_pkg;

  // Register port widths
  localparam int unsigned RegAddrWidth = 6;
  localparam int unsigned RegDataWidth = 32;

  // Width of the per-core mismatch counters
  localparam int unsigned MismatchCntWidth = 8;

  typedef logic [RegAddrWidth-1:0]     reg_addr_t;
  typedef logic [RegDataWidth-1:0]     reg_data_t;
  typedef logic [MismatchCntWidth-1:0] mismatch_cnt_t;

  // Operating mode of a single core
  typedef enum logic [1:0] {
    mode_independent = 2'd0,
    mode_dual        = 2'd1,
    mode_triple      = 2'd2
  } core_mode_e;

  // Word addresses on the register port

  // Bit g enables TMR group g
  localparam reg_addr_t AddrTmrEnable    = reg_addr_t'(0);
  // Bit g enables DMR group g
  localparam reg_addr_t AddrDmrEnable    = reg_addr_t'(1);
  // Read only, two bits per core
  localparam reg_addr_t AddrCoreMode     = reg_addr_t'(2);
  // Counter of core i sits at AddrMismatchBase + i, any write clears it
  localparam reg_addr_t AddrMismatchBase = reg_addr_t'(8);

endpackage

//--- logic/hmr_tmr_voter.sv
module hmr_tmr_voter #(
  parameter int unsigned DataWidth = 32
) (
  input  logic [DataWidth-1:0] a_i,
  input  logic [DataWidth-1:0] b_i,
  input  logic [DataWidth-1:0] c_i,
  output logic [DataWidth-1:0] majority_o,
  output logic [2:0]           error_o,
  output logic                 failure_o
);

  logic [DataWidth-1:0] majority;

  // Two out of three per bit
  assign majority = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  assign majority_o = majority;

  // Flag every input that differs anywhere from the voted word
  assign error_o[0] = (a_i != majority);
  assign error_o[1] = (b_i != majority);
  assign error_o[2] = (c_i != majority);

  // A flipped bit in one input leaves the other two matching the majority
  // at that position, so no input agreeing on every bit means all flagged
  assign failure_o = &error_o;

endmodule

//--- logic/hmr_config_regs.sv
module hmr_config_regs #(
  parameter int unsigned NumCores = 6
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,

  // Register request
  input  logic                                 reg_valid_i,
  output logic                                 reg_ready_o,
  input  logic                                 reg_write_i,
  input  hmr_pkg::reg_addr_t                   reg_addr_i,
  input  hmr_pkg::reg_data_t                   reg_wdata_i,

  // Register response
  output logic                                 rsp_valid_o,
  input  logic                                 rsp_ready_i,
  output hmr_pkg::reg_data_t                   rsp_rdata_o,
  output logic                                 rsp_error_o,

  input  logic               [NumCores-1:0]    core_mismatch_i,
  output hmr_pkg::core_mode_e [NumCores-1:0]   core_mode_o
);

  localparam int unsigned NumTmrGroups = NumCores / 3;
  localparam int unsigned NumDmrGroups = NumCores / 2;

  logic [NumTmrGroups-1:0] tmr_en_q;
  logic [NumDmrGroups-1:0] dmr_en_q;
  logic [NumDmrGroups-1:0] dmr_grp_active;

  hmr_pkg::mismatch_cnt_t [NumCores-1:0] cnt_q;
  logic [NumCores-1:0] cnt_sel;

  logic               accept;
  logic               addr_hit;
  logic               rsp_error_d;
  logic               wr_en;
  hmr_pkg::reg_data_t rd_data;

  logic               rsp_valid_q;
  logic               rsp_error_q;
  hmr_pkg::reg_data_t rsp_rdata_q;

  // Only one response is outstanding at a time
  assign reg_ready_o = ~rsp_valid_q;
  assign accept      = reg_valid_i & reg_ready_o;

  for (genvar i = 0; i < NumCores; i++) begin : gen_cnt_sel
    assign cnt_sel[i] = (reg_addr_i == hmr_pkg::reg_addr_t'(hmr_pkg::AddrMismatchBase + i));
  end

  // Address decode and read mux
  always_comb begin
    rd_data  = '0;
    addr_hit = 1'b0;
    case (reg_addr_i)
      hmr_pkg::AddrTmrEnable: begin
        addr_hit                   = 1'b1;
        rd_data[NumTmrGroups-1:0] = tmr_en_q;
      end
      hmr_pkg::AddrDmrEnable: begin
        addr_hit                   = 1'b1;
        rd_data[NumDmrGroups-1:0] = dmr_en_q;
      end
      hmr_pkg::AddrCoreMode: begin
        addr_hit = 1'b1;
        for (int i = 0; i < NumCores; i++) begin
          rd_data[2*i +: 2] = core_mode_o[i];
        end
      end
      default: begin
        addr_hit = 1'b0;
      end
    endcase
    for (int i = 0; i < NumCores; i++) begin
      if (cnt_sel[i]) begin
        addr_hit = 1'b1;
        rd_data[hmr_pkg::MismatchCntWidth-1:0] = cnt_q[i];
      end
    end
  end

  // Mode register is read only
  assign rsp_error_d = ~addr_hit | (reg_write_i & (reg_addr_i == hmr_pkg::AddrCoreMode));
  assign wr_en       = accept & reg_write_i & ~rsp_error_d;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tmr_en_q <= '0;
      dmr_en_q <= '0;
    end else if (wr_en) begin
      if (reg_addr_i == hmr_pkg::AddrTmrEnable) begin
        tmr_en_q <= reg_wdata_i[NumTmrGroups-1:0];
      end
      if (reg_addr_i == hmr_pkg::AddrDmrEnable) begin
        dmr_en_q <= reg_wdata_i[NumDmrGroups-1:0];
      end
    end
  end

  // Saturating mismatch counters, a clear wins over an increment
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NumCores; i++) begin
        if (wr_en && cnt_sel[i]) begin
          cnt_q[i] <= '0;
        end else if (core_mismatch_i[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // Response held until the host takes it
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      rsp_error_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
      rsp_error_q <= rsp_error_d;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_rdata_q <= reg_write_i ? '0 : rd_data;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_error_o = rsp_error_q;
  assign rsp_rdata_o = rsp_rdata_q;

  // DMR group is dropped when either of its cores is claimed by TMR
  for (genvar g = 0; g < NumDmrGroups; g++) begin : gen_dmr_active
    localparam int unsigned TmrGrpA = g % NumTmrGroups;
    localparam int unsigned TmrGrpB = (g + NumDmrGroups) % NumTmrGroups;
    assign dmr_grp_active[g] = dmr_en_q[g] & ~tmr_en_q[TmrGrpA] & ~tmr_en_q[TmrGrpB];
  end

  for (genvar i = 0; i < NumCores; i++) begin : gen_core_mode
    localparam int unsigned TmrGrp = i % NumTmrGroups;
    localparam int unsigned DmrGrp = i % NumDmrGroups;
    assign core_mode_o[i] = tmr_en_q[TmrGrp]       ? hmr_pkg::mode_triple :
                            dmr_grp_active[DmrGrp] ? hmr_pkg::mode_dual   :
                                                     hmr_pkg::mode_independent;
  end

endmodule

//--- logic/hmr_fault_detect.sv
module hmr_fault_detect #(
  parameter  int unsigned NumCores     = 6,
  parameter  int unsigned DataWidth    = 32,
  localparam int unsigned NumTmrGroups = NumCores / 3,
  localparam int unsigned NumDmrGroups = NumCores / 2
) (
  input  logic                [NumCores-1:0][DataWidth-1:0]     core_outputs_i,
  input  hmr_pkg::core_mode_e [NumCores-1:0]                    core_mode_i,

  output logic                [NumTmrGroups-1:0][DataWidth-1:0] voted_data_o,
  output logic                [NumDmrGroups-1:0][DataWidth-1:0] checked_data_o,

  output logic                [NumTmrGroups-1:0]                tmr_failure_o,
  output logic                [NumCores-1:0]                    tmr_error_o,
  output logic                [NumDmrGroups-1:0]                dmr_failure_o,
  output logic                [NumCores-1:0]                    core_mismatch_o
);

  logic [NumTmrGroups-1:0][2:0] tmr_error;
  logic [NumTmrGroups-1:0]      tmr_failure;
  logic [NumDmrGroups-1:0]      dmr_failure;

  // Interleaved TMR groups: cores g, g+N/3 and g+2N/3
  for (genvar g = 0; g < NumTmrGroups; g++) begin : gen_tmr_groups
    hmr_tmr_voter #(
      .DataWidth ( DataWidth )
    ) u_voter (
      .a_i        ( core_outputs_i[g]                  ),
      .b_i        ( core_outputs_i[g +     NumTmrGroups] ),
      .c_i        ( core_outputs_i[g + 2 * NumTmrGroups] ),
      .majority_o ( voted_data_o[g]                    ),
      .error_o    ( tmr_error[g]                       ),
      .failure_o  ( tmr_failure[g]                     )
    );

    // Report only while the group is running in lockstep
    assign tmr_failure_o[g] = (core_mode_i[g] == hmr_pkg::mode_triple) & tmr_failure[g];
  end

  // Interleaved DMR groups: cores g and g+N/2
  for (genvar g = 0; g < NumDmrGroups; g++) begin : gen_dmr_groups
    assign checked_data_o[g] = core_outputs_i[g];
    assign dmr_failure[g]    = (core_outputs_i[g] != core_outputs_i[g + NumDmrGroups]);
    assign dmr_failure_o[g]  = (core_mode_i[g] == hmr_pkg::mode_dual) & dmr_failure[g];
  end

  for (genvar i = 0; i < NumCores; i++) begin : gen_core_flags
    localparam int unsigned TmrGrp = i % NumTmrGroups;
    localparam int unsigned TmrOff = i / NumTmrGroups;
    localparam int unsigned DmrGrp = i % NumDmrGroups;

    // Gated on the main slot, which shares its mode with the whole group
    assign tmr_error_o[i] = (core_mode_i[TmrGrp] == hmr_pkg::mode_triple) &
                            tmr_error[TmrGrp][TmrOff];

    always_comb begin
      case (core_mode_i[i])
        hmr_pkg::mode_triple: core_mismatch_o[i] = tmr_error_o[i];
        hmr_pkg::mode_dual:   core_mismatch_o[i] = dmr_failure_o[DmrGrp];
        default:              core_mismatch_o[i] = 1'b0;
      endcase
    end
  end

endmodule

//--- logic/hmr_core_router.sv
module hmr_core_router #(
  parameter  int unsigned NumCores     = 6,
  parameter  int unsigned DataWidth    = 32,
  localparam int unsigned NumTmrGroups = NumCores / 3,
  localparam int unsigned NumDmrGroups = NumCores / 2
) (
  input  hmr_pkg::core_mode_e [NumCores-1:0]                    core_mode_i,

  // Towards the cores
  input  logic                [NumCores-1:0][DataWidth-1:0]     sys_inputs_i,
  output logic                [NumCores-1:0][DataWidth-1:0]     core_inputs_o,

  // Towards the system
  input  logic                [NumCores-1:0][DataWidth-1:0]     core_outputs_i,
  input  logic                [NumTmrGroups-1:0][DataWidth-1:0] voted_data_i,
  input  logic                [NumDmrGroups-1:0][DataWidth-1:0] checked_data_i,
  output logic                [NumCores-1:0][DataWidth-1:0]     sys_outputs_o,

  output logic                [NumCores-1:0]                    tmr_core_en_o,
  output logic                [NumCores-1:0]                    dmr_core_en_o
);

  for (genvar i = 0; i < NumCores; i++) begin : gen_cores
    // Main slot of the groups this core can belong to
    localparam int unsigned TmrMain = i % NumTmrGroups;
    localparam int unsigned DmrMain = i % NumDmrGroups;

    // Redundant cores all see the main slot's input
    always_comb begin
      case (core_mode_i[i])
        hmr_pkg::mode_triple: core_inputs_o[i] = sys_inputs_i[TmrMain];
        hmr_pkg::mode_dual:   core_inputs_o[i] = sys_inputs_i[DmrMain];
        default:              core_inputs_o[i] = sys_inputs_i[i];
      endcase
    end

    // Voted or checked word at the main slot, other group slots read zero
    always_comb begin
      case (core_mode_i[i])
        hmr_pkg::mode_triple: begin
          if (i == TmrMain) begin
            sys_outputs_o[i] = voted_data_i[TmrMain];
          end else begin
            sys_outputs_o[i] = '0;
          end
        end
        hmr_pkg::mode_dual: begin
          if (i == DmrMain) begin
            sys_outputs_o[i] = checked_data_i[DmrMain];
          end else begin
            sys_outputs_o[i] = '0;
          end
        end
        default: begin
          sys_outputs_o[i] = core_outputs_i[i];
        end
      endcase
    end

    assign tmr_core_en_o[i] = (core_mode_i[i] == hmr_pkg::mode_triple);
    assign dmr_core_en_o[i] = (core_mode_i[i] == hmr_pkg::mode_dual);
  end

endmodule

//--- logic/hmr_unit.sv
module hmr_unit #(
  parameter  int unsigned NumCores     = 6,
  parameter  int unsigned DataWidth    = 32,
  localparam int unsigned NumTmrGroups = NumCores / 3,
  localparam int unsigned NumDmrGroups = NumCores / 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,

  // Configuration register port
  input  logic                                  reg_valid_i,
  output logic                                  reg_ready_o,
  input  logic                                  reg_write_i,
  input  hmr_pkg::reg_addr_t                    reg_addr_i,
  input  hmr_pkg::reg_data_t                    reg_wdata_i,
  output logic                                  rsp_valid_o,
  input  logic                                  rsp_ready_i,
  output hmr_pkg::reg_data_t                    rsp_rdata_o,
  output logic                                  rsp_error_o,

  // System side
  input  logic [NumCores-1:0][DataWidth-1:0]    sys_inputs_i,
  output logic [NumCores-1:0][DataWidth-1:0]    sys_outputs_o,

  // Core side
  output logic [NumCores-1:0][DataWidth-1:0]    core_inputs_o,
  input  logic [NumCores-1:0][DataWidth-1:0]    core_outputs_i,

  // Status
  output logic [NumCores-1:0]                   tmr_core_en_o,
  output logic [NumCores-1:0]                   dmr_core_en_o,
  output logic [NumTmrGroups-1:0]               tmr_failure_o,
  output logic [NumCores-1:0]                   tmr_error_o,
  output logic [NumDmrGroups-1:0]               dmr_failure_o
);

  hmr_pkg::core_mode_e [NumCores-1:0]                    core_mode;
  logic                [NumCores-1:0]                    core_mismatch;
  logic                [NumTmrGroups-1:0][DataWidth-1:0] voted_data;
  logic                [NumDmrGroups-1:0][DataWidth-1:0] checked_data;

  hmr_config_regs #(
    .NumCores ( NumCores )
  ) u_config_regs (
    .clk_i           ( clk_i         ),
    .rst_i           ( rst_i         ),
    .reg_valid_i     ( reg_valid_i   ),
    .reg_ready_o     ( reg_ready_o   ),
    .reg_write_i     ( reg_write_i   ),
    .reg_addr_i      ( reg_addr_i    ),
    .reg_wdata_i     ( reg_wdata_i   ),
    .rsp_valid_o     ( rsp_valid_o   ),
    .rsp_ready_i     ( rsp_ready_i   ),
    .rsp_rdata_o     ( rsp_rdata_o   ),
    .rsp_error_o     ( rsp_error_o   ),
    .core_mismatch_i ( core_mismatch ),
    .core_mode_o     ( core_mode     )
  );

  hmr_fault_detect #(
    .NumCores  ( NumCores  ),
    .DataWidth ( DataWidth )
  ) u_fault_detect (
    .core_outputs_i  ( core_outputs_i ),
    .core_mode_i     ( core_mode      ),
    .voted_data_o    ( voted_data     ),
    .checked_data_o  ( checked_data   ),
    .tmr_failure_o   ( tmr_failure_o  ),
    .tmr_error_o     ( tmr_error_o    ),
    .dmr_failure_o   ( dmr_failure_o  ),
    .core_mismatch_o ( core_mismatch  )
  );

  hmr_core_router #(
    .NumCores  ( NumCores  ),
    .DataWidth ( DataWidth )
  ) u_core_router (
    .core_mode_i    ( core_mode      ),
    .sys_inputs_i   ( sys_inputs_i   ),
    .core_inputs_o  ( core_inputs_o  ),
    .core_outputs_i ( core_outputs_i ),
    .voted_data_i   ( voted_data     ),
    .checked_data_i ( checked_data   ),
    .sys_outputs_o  ( sys_outputs_o  ),
    .tmr_core_en_o  ( tmr_core_en_o  ),
    .dmr_core_en_o  ( dmr_core_en_o  )
  );

endmodule

//--- tests/hmr_ref_model.svh
`ifndef HMR_REF_MODEL_SVH
`define HMR_REF_MODEL_SVH

// Expected behavior, worked out from the model enables m_tmr_en and m_dmr_en

function automatic hmr_pkg::core_mode_e ref_mode(input int core);
  int dgrp;
  dgrp = core % NumDmr;
  if (m_tmr_en[core % NumTmr]) begin
    return hmr_pkg::mode_triple;
  end
  // A DMR pair only runs while no TMR group holds either of its cores
  if (m_dmr_en[dgrp] && !m_tmr_en[dgrp % NumTmr] && !m_tmr_en[(dgrp + NumDmr) % NumTmr]) begin
    return hmr_pkg::mode_dual;
  end
  return hmr_pkg::mode_independent;
endfunction

function automatic int ref_main(input int core);
  case (ref_mode(core))
    hmr_pkg::mode_triple: return core % NumTmr;
    hmr_pkg::mode_dual:   return core % NumDmr;
    default:              return core;
  endcase
endfunction

// At least two ones out of three, bit by bit
function automatic word_t ref_vote(input word_t a, input word_t b, input word_t c);
  word_t res;
  for (int k = 0; k < DataWidth; k++) begin
    res[k] = (int'(a[k]) + int'(b[k]) + int'(c[k])) >= 2;
  end
  return res;
endfunction

function automatic void ref_route(input word_vec_t sys_in, input word_vec_t outs,
                                  output word_vec_t core_in, output word_vec_t sys_out);
  for (int i = 0; i < NumCores; i++) begin
    core_in[i] = sys_in[ref_main(i)];
    if (ref_mode(i) == hmr_pkg::mode_independent) begin
      sys_out[i] = outs[i];
    end else if (ref_main(i) != i) begin
      sys_out[i] = '0;
    end else if (ref_mode(i) == hmr_pkg::mode_triple) begin
      sys_out[i] = ref_vote(outs[i], outs[i + NumTmr], outs[i + 2 * NumTmr]);
    end else begin
      sys_out[i] = outs[i];
    end
  end
endfunction

function automatic void ref_faults(input word_vec_t outs, output logic [NumTmr-1:0] tmr_fail,
                                   output logic [NumCores-1:0] tmr_err,
                                   output logic [NumDmr-1:0] dmr_fail,
                                   output logic [NumCores-1:0] mismatch);
  word_t maj;
  tmr_fail = '0;
  tmr_err  = '0;
  for (int g = 0; g < NumTmr; g++) begin
    if (m_tmr_en[g]) begin
      maj = ref_vote(outs[g], outs[g + NumTmr], outs[g + 2 * NumTmr]);
      for (int k = 0; k < 3; k++) begin
        tmr_err[g + k * NumTmr] = (outs[g + k * NumTmr] != maj);
      end
      // Failed when not one member matches the voted word
      tmr_fail[g] = tmr_err[g] && tmr_err[g + NumTmr] && tmr_err[g + 2 * NumTmr];
    end
  end
  for (int g = 0; g < NumDmr; g++) begin
    dmr_fail[g] = (ref_mode(g) == hmr_pkg::mode_dual) && (outs[g] != outs[g + NumDmr]);
  end
  for (int i = 0; i < NumCores; i++) begin
    case (ref_mode(i))
      hmr_pkg::mode_triple: mismatch[i] = tmr_err[i];
      hmr_pkg::mode_dual:   mismatch[i] = dmr_fail[i % NumDmr];
      default:              mismatch[i] = 1'b0;
    endcase
  end
endfunction

function automatic logic ref_reg_error(input logic wr, input hmr_pkg::reg_addr_t addr);
  logic mapped;
  mapped = (addr == hmr_pkg::AddrTmrEnable) || (addr == hmr_pkg::AddrDmrEnable) ||
           (addr == hmr_pkg::AddrCoreMode) ||
           (addr >= hmr_pkg::AddrMismatchBase && addr < hmr_pkg::AddrMismatchBase + NumCores);
  return !mapped || (wr && addr == hmr_pkg::AddrCoreMode);
endfunction

function automatic hmr_pkg::reg_data_t ref_read(input hmr_pkg::reg_addr_t addr);
  hmr_pkg::reg_data_t res;
  res = '0;
  if (addr == hmr_pkg::AddrTmrEnable) begin
    res[NumTmr-1:0] = m_tmr_en;
  end else if (addr == hmr_pkg::AddrDmrEnable) begin
    res[NumDmr-1:0] = m_dmr_en;
  end else if (addr == hmr_pkg::AddrCoreMode) begin
    for (int i = 0; i < NumCores; i++) begin
      res[2*i +: 2] = ref_mode(i);
    end
  end else if (addr >= hmr_pkg::AddrMismatchBase && addr < hmr_pkg::AddrMismatchBase + NumCores) begin
    res[7:0] = m_cnt[addr - hmr_pkg::AddrMismatchBase];
  end
  return res;
endfunction

`endif

//--- tests/tb_hmr_unit.sv
module tb_hmr_unit;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumCores      = 6;
  localparam int DataWidth     = 32;
  localparam int NumTmr        = NumCores / 3;
  localparam int NumDmr        = NumCores / 2;
  localparam int TimeoutCycles = 2000;

  typedef logic [DataWidth-1:0] word_t;
  typedef logic [NumCores-1:0][DataWidth-1:0] word_vec_t;

  logic clk_i = 1'b0;
  logic rst_i;
  logic reg_valid_i, reg_ready_o, reg_write_i, rsp_valid_o, rsp_ready_i, rsp_error_o;
  hmr_pkg::reg_addr_t reg_addr_i;
  hmr_pkg::reg_data_t reg_wdata_i, rsp_rdata_o;
  word_vec_t sys_inputs_i, sys_outputs_o, core_inputs_o, core_outputs_i;
  logic [NumCores-1:0] tmr_core_en_o, dmr_core_en_o, tmr_error_o;
  logic [NumTmr-1:0] tmr_failure_o;
  logic [NumDmr-1:0] dmr_failure_o;

  // Model state, and its value after the coming edge
  logic [NumTmr-1:0] m_tmr_en, n_tmr_en = '0;
  logic [NumDmr-1:0] m_dmr_en, n_dmr_en = '0;
  hmr_pkg::mismatch_cnt_t [NumCores-1:0] m_cnt, n_cnt = '0;
  logic m_rsp_valid, n_rsp_valid = 1'b0;
  int unsigned cycles = 0;
  hmr_pkg::reg_data_t rd;
  logic er;

  `include "hmr_ref_model.svh"

  hmr_unit u_dut (.*);

  always #5 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [255:0] got, input logic [255:0] exp);
    if (got !== exp) begin
      $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  function automatic word_vec_t rand_vec();
    word_vec_t v;
    for (int i = 0; i < NumCores; i++) begin
      v[i] = $urandom;
    end
    return v;
  endfunction

  task automatic drive_data(input word_vec_t sys_in, input word_vec_t outs);
    @(posedge clk_i);
    sys_inputs_i   <= sys_in;
    core_outputs_i <= outs;
  endtask

  task automatic reg_access(input logic wr, input hmr_pkg::reg_addr_t addr,
                            input hmr_pkg::reg_data_t wdata,
                            output hmr_pkg::reg_data_t rdata, output logic err);
    hmr_pkg::reg_data_t exp_rdata;
    logic exp_err;
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_write_i <= wr;
    reg_addr_i  <= addr;
    reg_wdata_i <= wdata;
    @(negedge clk_i);
    while (!reg_ready_o) begin
      @(negedge clk_i);
    end
    // Taken at the next edge, so the response reflects the state seen now
    exp_err   = ref_reg_error(wr, addr);
    exp_rdata = (wr || exp_err) ? '0 : ref_read(addr);
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    @(negedge clk_i);
    while (!rsp_valid_o) begin
      @(negedge clk_i);
    end
    check_value("rsp_error_o", rsp_error_o, exp_err);
    check_value("rsp_rdata_o", rsp_rdata_o, exp_rdata);
    rdata = rsp_rdata_o;
    err   = rsp_error_o;
  endtask

  // Compare against the reference, then work out the model's next state
  always @(negedge clk_i) begin
    word_vec_t exp_in, exp_out;
    logic [NumTmr-1:0] exp_tfail;
    logic [NumDmr-1:0] exp_dfail;
    logic [NumCores-1:0] exp_terr, exp_mis, exp_ten, exp_den;
    logic accept, wr_ok;
    if (rst_i) begin
      n_tmr_en    = '0;
      n_dmr_en    = '0;
      n_cnt       = '0;
      n_rsp_valid = 1'b0;
    end else begin
      ref_route(sys_inputs_i, core_outputs_i, exp_in, exp_out);
      ref_faults(core_outputs_i, exp_tfail, exp_terr, exp_dfail, exp_mis);
      for (int i = 0; i < NumCores; i++) begin
        exp_ten[i] = (ref_mode(i) == hmr_pkg::mode_triple);
        exp_den[i] = (ref_mode(i) == hmr_pkg::mode_dual);
      end
      check_value("core_inputs_o", core_inputs_o, exp_in);
      check_value("sys_outputs_o", sys_outputs_o, exp_out);
      check_value("tmr_core_en_o", tmr_core_en_o, exp_ten);
      check_value("dmr_core_en_o", dmr_core_en_o, exp_den);
      check_value("tmr_failure_o", tmr_failure_o, exp_tfail);
      check_value("tmr_error_o", tmr_error_o, exp_terr);
      check_value("dmr_failure_o", dmr_failure_o, exp_dfail);
      check_value("rsp_valid_o", rsp_valid_o, m_rsp_valid);
      check_value("reg_ready_o", reg_ready_o, !m_rsp_valid);
      accept      = reg_valid_i && !m_rsp_valid;
      wr_ok       = accept && reg_write_i && !ref_reg_error(1'b1, reg_addr_i);
      n_rsp_valid = accept || (m_rsp_valid && !rsp_ready_i);
      n_tmr_en    = (wr_ok && reg_addr_i == hmr_pkg::AddrTmrEnable) ?
                    reg_wdata_i[NumTmr-1:0] : m_tmr_en;
      n_dmr_en    = (wr_ok && reg_addr_i == hmr_pkg::AddrDmrEnable) ?
                    reg_wdata_i[NumDmr-1:0] : m_dmr_en;
      for (int i = 0; i < NumCores; i++) begin
        if (wr_ok && reg_addr_i == hmr_pkg::AddrMismatchBase + i) begin
          n_cnt[i] = '0;
        end else if (exp_mis[i] && m_cnt[i] != '1) begin
          n_cnt[i] = m_cnt[i] + 1'b1;
        end else begin
          n_cnt[i] = m_cnt[i];
        end
      end
    end
  end

  always @(posedge clk_i) begin
    m_tmr_en    <= n_tmr_en;
    m_dmr_en    <= n_dmr_en;
    m_cnt       <= n_cnt;
    m_rsp_valid <= n_rsp_valid;
    cycles      <= cycles + 1;
    if (cycles == TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Checks failed");
      $fatal(1);
    end
  end

  initial begin
    word_vec_t outs, sys_in;
    word_t base;
    void'($urandom(15));
    rst_i          = 1'b1;
    reg_valid_i    = 1'b0;
    reg_write_i    = 1'b0;
    reg_addr_i     = '0;
    reg_wdata_i    = '0;
    rsp_ready_i    = 1'b1;
    sys_inputs_i   = rand_vec();
    core_outputs_i = rand_vec();
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    // Everything reads zero out of reset
    for (int a = 0; a < 3; a++) begin
      reg_access(1'b0, hmr_pkg::reg_addr_t'(a), '0, rd, er);
      check_value("reset register", rd, 0);
    end
    for (int i = 0; i < NumCores; i++) begin
      reg_access(1'b0, hmr_pkg::reg_addr_t'(hmr_pkg::AddrMismatchBase + i), '0, rd, er);
    end

    // TMR group 0 with core 2 off by one bit
    sys_in  = rand_vec();
    outs    = rand_vec();
    outs[2] = outs[0] ^ 32'h100;
    outs[4] = outs[0];
    drive_data(sys_in, outs);
    reg_access(1'b1, hmr_pkg::AddrTmrEnable, 32'h1, rd, er);
    check_value("tmr_error_o", tmr_error_o, 6'b000100);
    check_value("tmr_failure_o", tmr_failure_o, 2'b00);
    check_value("sys_outputs_o[0]", sys_outputs_o[0], outs[0]);
    check_value("sys_outputs_o[2]", sys_outputs_o[2], 0);
    check_value("core_inputs_o[4]", core_inputs_o[4], sys_in[0]);
    base    = outs[0];
    outs[0] = base ^ 32'h2;
    outs[4] = base ^ 32'h1;
    drive_data(sys_in, outs);
    @(negedge clk_i);
    check_value("tmr_failure_o", tmr_failure_o, 2'b01);

    // DMR group 1, then a TMR group that takes core 4 away from it
    reg_access(1'b1, hmr_pkg::AddrTmrEnable, 32'h0, rd, er);
    reg_access(1'b1, hmr_pkg::AddrDmrEnable, 32'h2, rd, er);
    outs    = rand_vec();
    outs[4] = outs[1] ^ 32'h10;
    drive_data(rand_vec(), outs);
    @(negedge clk_i);
    check_value("dmr_failure_o", dmr_failure_o, 3'b010);
    check_value("sys_outputs_o[1]", sys_outputs_o[1], outs[1]);
    reg_access(1'b1, hmr_pkg::AddrTmrEnable, 32'h1, rd, er);
    reg_access(1'b0, hmr_pkg::AddrCoreMode, '0, rd, er);
    check_value("core mode register", rd, 32'h222);
    check_value("dmr_failure_o", dmr_failure_o, 3'b000);

    // Mismatch counter of core 4 in TMR group 0
    reg_access(1'b1, hmr_pkg::AddrDmrEnable, 32'h0, rd, er);
    outs[2] = outs[0];
    outs[4] = outs[0];
    drive_data(sys_in, outs);
    for (int i = 0; i < NumCores; i++) begin
      reg_access(1'b1, hmr_pkg::reg_addr_t'(hmr_pkg::AddrMismatchBase + i), '0, rd, er);
    end
    drive_data(sys_in, outs ^ (word_vec_t'(32'h4) << (4 * DataWidth)));
    repeat (19) @(posedge clk_i);
    drive_data(sys_in, outs);
    reg_access(1'b0, hmr_pkg::AddrMismatchBase + 4, '0, rd, er);
    check_value("mismatch count", rd, 20);
    drive_data(sys_in, outs ^ (word_vec_t'(32'h4) << (4 * DataWidth)));
    repeat (300) @(posedge clk_i);
    reg_access(1'b0, hmr_pkg::AddrMismatchBase + 4, '0, rd, er);
    check_value("mismatch count", rd, 255);
    drive_data(sys_in, outs);
    reg_access(1'b1, hmr_pkg::AddrMismatchBase + 4, '1, rd, er);
    reg_access(1'b0, hmr_pkg::AddrMismatchBase + 4, '0, rd, er);
    check_value("mismatch count", rd, 0);

    // Bad addresses, the read-only mode register and a held response
    reg_access(1'b0, 6'h3f, '0, rd, er);
    check_value("rsp_error_o", er, 1);
    reg_access(1'b1, hmr_pkg::AddrCoreMode, '1, rd, er);
    check_value("rsp_error_o", er, 1);
    reg_access(1'b0, hmr_pkg::AddrTmrEnable, '0, rd, er);
    check_value("tmr enable register", rd, 1);
    @(posedge clk_i);
    rsp_ready_i <= 1'b0;
    reg_access(1'b0, hmr_pkg::AddrCoreMode, '0, rd, er);
    repeat (4) begin
      @(negedge clk_i);
      check_value("rsp_valid_o", rsp_valid_o, 1);
      check_value("rsp_rdata_o", rsp_rdata_o, rd);
      check_value("rsp_error_o", rsp_error_o, er);
      check_value("reg_ready_o", reg_ready_o, 0);
    end
    @(posedge clk_i);
    rsp_ready_i <= 1'b1;
    // The response is released by the first edge that sees ready high
    @(posedge clk_i);
    @(negedge clk_i);
    check_value("rsp_valid_o", rsp_valid_o, 0);

    // Random enables and mostly agreeing cores with the odd flipped bit
    for (int n = 0; n < 200; n++) begin
      if (n % 25 == 0) begin
        reg_access(1'b1, hmr_pkg::AddrTmrEnable, $urandom, rd, er);
        reg_access(1'b1, hmr_pkg::AddrDmrEnable, $urandom, rd, er);
      end
      base = $urandom;
      for (int i = 0; i < NumCores; i++) begin
        outs[i] = ($urandom % 4 == 0) ? base ^ (32'h1 << ($urandom % DataWidth)) : base;
      end
      drive_data(rand_vec(), outs);
    end
    for (int i = 0; i < NumCores; i++) begin
      reg_access(1'b0, hmr_pkg::reg_addr_t'(hmr_pkg::AddrMismatchBase + i), '0, rd, er);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

//--- files.f
+incdir+tests
logic/hmr_pkg.sv
logic/hmr_tmr_voter.sv
logic/hmr_config_regs.sv
logic/hmr_fault_detect.sv
logic/hmr_core_router.sv
logic/hmr_unit.sv
tests/tb_hmr_unit.sv
